// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ex_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out=$$(./$(SIM_BIN)); echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

// ==== project.f ====
rtl/ex_pkg.sv
rtl/div_unit.sv
rtl/alu.sv
rtl/hilo_reg.sv
rtl/cp0_regs.sv
rtl/ex.sv
rtl/ex_top.sv
sim/tb_ex_top.sv

// ==== rtl/alu.sv ====
`default_nettype none

module alu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      go,
    input  ex_pkg::alu_op_t           alu_op,
    input  logic [ex_pkg::data_w-1:0] src_a,
    input  logic [ex_pkg::data_w-1:0] src_b,
    output logic [ex_pkg::data_w-1:0] res,
    output logic [ex_pkg::data_w-1:0] hi_res,
    output logic [ex_pkg::data_w-1:0] lo_res,
    output logic                      busy,
    output logic                      done
);

    import ex_pkg::*;

    logic [4:0]          shamt;
    logic                mul_signed;
    logic [2*data_w-1:0] mul_a;
    logic [2*data_w-1:0] mul_b;
    logic [2*data_w-1:0] product;
    logic                is_div;
    logic [data_w-1:0]   div_quo;
    logic [data_w-1:0]   div_rem;

    assign shamt = src_a[4:0];

    // extend to 64 bits, the low half of the product is then exact
    assign mul_signed = (alu_op == alu_mult);
    assign mul_a      = {{data_w{mul_signed & src_a[data_w-1]}}, src_a};
    assign mul_b      = {{data_w{mul_signed & src_b[data_w-1]}}, src_b};
    assign product    = mul_a * mul_b;

    always_comb begin
        case (alu_op)
            alu_add:  res = src_a + src_b;
            alu_sub:  res = src_a - src_b;
            alu_and:  res = src_a & src_b;
            alu_or:   res = src_a | src_b;
            alu_xor:  res = src_a ^ src_b;
            alu_nor:  res = ~(src_a | src_b);
            alu_slt:  res = {{(data_w-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            alu_sltu: res = {{(data_w-1){1'b0}}, src_a < src_b};
            alu_sll:  res = src_b << shamt;
            alu_srl:  res = src_b >> shamt;
            alu_sra:  res = $signed(src_b) >>> shamt;
            alu_lui:  res = {src_b[15:0], 16'h0000};
            alu_move: res = src_a;
            default:  res = '0;
        endcase
    end

    // divider result wins once it is ready
    always_comb begin
        if (done) begin
            hi_res = div_rem;
            lo_res = div_quo;
        end else begin
            case (alu_op)
                alu_mult, alu_multu: begin
                    hi_res = product[2*data_w-1:data_w];
                    lo_res = product[data_w-1:0];
                end
                alu_move: begin
                    hi_res = src_a;
                    lo_res = src_a;
                end
                default: begin
                    hi_res = '0;
                    lo_res = '0;
                end
            endcase
        end
    end

    assign is_div = (alu_op == alu_div) || (alu_op == alu_divu);

    div_unit i_div_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (go && is_div),
        .signed_op (alu_op == alu_div),
        .dividend  (src_a),
        .divisor   (src_b),
        .busy      (busy),
        .done      (done),
        .quotient  (div_quo),
        .remainder (div_rem)
    );

endmodule

`default_nettype wire

// ==== rtl/cp0_regs.sv ====
`default_nettype none

module cp0_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          w_ena,
    input  logic [ex_pkg::reg_addr_w-1:0] w_addr,
    input  logic [ex_pkg::data_w-1:0]     w_data,
    input  logic [ex_pkg::reg_addr_w-1:0] r_addr,
    output logic [ex_pkg::data_w-1:0]     r_data
);

    import ex_pkg::*;

    logic [data_w-1:0] status;
    logic [data_w-1:0] cause;
    logic [data_w-1:0] epc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status <= '0;
            cause  <= '0;
            epc    <= '0;
        end else if (w_ena) begin
            case (w_addr)
                cp0_status: status <= w_data;
                cp0_cause:  cause  <= w_data;
                cp0_epc:    epc    <= w_data;
                default:    ;
            endcase
        end
    end

    // unimplemented registers read as zero
    always_comb begin
        case (r_addr)
            cp0_status: r_data = status;
            cp0_cause:  r_data = cause;
            cp0_epc:    r_data = epc;
            default:    r_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/div_unit.sv ====
`default_nettype none

module div_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      signed_op,
    input  logic [ex_pkg::data_w-1:0] dividend,
    input  logic [ex_pkg::data_w-1:0] divisor,
    output logic                      busy,
    output logic                      done,
    output logic [ex_pkg::data_w-1:0] quotient,
    output logic [ex_pkg::data_w-1:0] remainder
);

    import ex_pkg::*;

    logic [div_cnt_w-1:0] step_cnt;
    logic [data_w-1:0]    rem_q;
    logic [data_w-1:0]    quo_q;
    logic [data_w-1:0]    dsr_q;
    logic                 q_neg;
    logic                 r_neg;

    logic                 a_neg;
    logic                 b_neg;
    logic [data_w:0]      trial;
    logic [data_w:0]      diff;
    logic                 fits;

    assign a_neg = signed_op & dividend[data_w-1];
    assign b_neg = signed_op & divisor[data_w-1];

    // shift in next dividend bit, subtract if it fits
    assign trial = {rem_q, quo_q[data_w-1]};
    assign diff  = trial - {1'b0, dsr_q};
    assign fits  = (trial >= {1'b0, dsr_q});

    assign done = busy && (step_cnt == div_cnt_w'(div_steps));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            step_cnt <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            step_cnt <= '0;
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_q <= '0;
            quo_q <= a_neg ? -dividend : dividend;
            dsr_q <= b_neg ? -divisor : divisor;
            q_neg <= a_neg ^ b_neg;
            r_neg <= a_neg;
        end else if (busy && !done) begin
            rem_q <= fits ? diff[data_w-1:0] : trial[data_w-1:0];
            quo_q <= {quo_q[data_w-2:0], fits};
        end
    end

    // sign fix on the unsigned result
    assign quotient  = q_neg ? -quo_q : quo_q;
    assign remainder = r_neg ? -rem_q : rem_q;

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);

    // done comes div_steps cycles into a run
    a_done_after_steps: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> ##div_steps done);

endmodule

`default_nettype wire

// ==== rtl/ex.sv ====
`default_nettype none

module ex (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  ex_pkg::src_a_sel_t            src_a_sel,
    input  ex_pkg::src_b_sel_t            src_b_sel,
    input  ex_pkg::alu_op_t               alu_op,
    input  ex_pkg::res_sel_t              res_sel,
    input  logic                          w_reg_ena,
    input  logic [ex_pkg::reg_addr_w-1:0] w_reg_dst,
    input  logic [1:0]                    w_hilo_ena,
    input  logic                          w_cp0_ena,
    input  logic [ex_pkg::reg_addr_w-1:0] rd,
    input  logic [ex_pkg::reg_addr_w-1:0] sa,
    input  logic [ex_pkg::data_w-1:0]     rs_data,
    input  logic [ex_pkg::data_w-1:0]     rt_data,
    input  logic [ex_pkg::data_w-1:0]     ext_imme,
    input  logic [ex_pkg::data_w-1:0]     pc,
    input  logic [ex_pkg::data_w-1:0]     hi,
    input  logic [ex_pkg::data_w-1:0]     lo,
    input  logic [ex_pkg::data_w-1:0]     cp0_r_data,
    output logic [1:0]                    hilo_w_ena,
    output logic [ex_pkg::data_w-1:0]     hi_in,
    output logic [ex_pkg::data_w-1:0]     lo_in,
    output logic                          cp0_w_ena,
    output logic [ex_pkg::reg_addr_w-1:0] cp0_addr,
    output logic [ex_pkg::data_w-1:0]     cp0_w_data,
    output logic                          out_valid,
    output logic [ex_pkg::data_w-1:0]     out_res,
    output logic                          out_w_reg_ena,
    output logic [ex_pkg::reg_addr_w-1:0] out_w_reg_dst,
    output logic [ex_pkg::data_w-1:0]     out_pc
);

    import ex_pkg::*;

    logic                  accept;
    logic                  is_div;
    logic [data_w-1:0]     src_a;
    logic [data_w-1:0]     src_b;
    logic [data_w-1:0]     alu_res;
    logic [data_w-1:0]     res;
    logic                  alu_busy;
    logic                  alu_done;

    // fields of the divide in flight
    logic [data_w-1:0]     hold_res;
    logic                  hold_w_reg_ena;
    logic [reg_addr_w-1:0] hold_w_reg_dst;
    logic [data_w-1:0]     hold_pc;
    logic [1:0]            hold_hilo_ena;

    assign in_ready = !alu_busy;
    assign accept   = in_valid && in_ready;
    assign is_div   = (alu_op == alu_div) || (alu_op == alu_divu);

    always_comb begin
        case (src_a_sel)
            src_a_rs: src_a = rs_data;
            src_a_rt: src_a = rt_data;
            src_a_sa: src_a = {{(data_w-reg_addr_w){1'b0}}, sa};
            default:  src_a = '0;
        endcase
    end

    always_comb begin
        case (src_b_sel)
            src_b_rt:   src_b = rt_data;
            src_b_imme: src_b = ext_imme;
            src_b_rs:   src_b = rs_data;
            default:    src_b = '0;
        endcase
    end

    always_comb begin
        case (res_sel)
            res_hi:   res = hi;
            res_lo:   res = lo;
            res_pc_8: res = pc + 32'd8;
            res_cp0:  res = cp0_r_data;
            default:  res = alu_res;
        endcase
    end

    assign cp0_w_ena  = accept && w_cp0_ena;
    assign cp0_addr   = rd;
    assign cp0_w_data = rt_data;

    // divide writes hi/lo on completion only
    always_comb begin
        if (alu_done) begin
            hilo_w_ena = hold_hilo_ena;
        end else if (accept && !is_div) begin
            hilo_w_ena = w_hilo_ena;
        end else begin
            hilo_w_ena = 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= (accept && !is_div) || alu_done;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !is_div) begin
            out_res       <= res;
            out_w_reg_ena <= w_reg_ena;
            out_w_reg_dst <= w_reg_dst;
            out_pc        <= pc;
        end else if (alu_done) begin
            out_res       <= hold_res;
            out_w_reg_ena <= hold_w_reg_ena;
            out_w_reg_dst <= hold_w_reg_dst;
            out_pc        <= hold_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_div) begin
            hold_res       <= res;
            hold_w_reg_ena <= w_reg_ena;
            hold_w_reg_dst <= w_reg_dst;
            hold_pc        <= pc;
            hold_hilo_ena  <= w_hilo_ena;
        end
    end

    alu i_alu (
        .clk    (clk),
        .rst_n  (rst_n),
        .go     (accept),
        .alu_op (alu_op),
        .src_a  (src_a),
        .src_b  (src_b),
        .res    (alu_res),
        .hi_res (hi_in),
        .lo_res (lo_in),
        .busy   (alu_busy),
        .done   (alu_done)
    );

    // one done pulse, so one result per divide
    a_div_one_result: assert property (@(posedge clk) disable iff (!rst_n)
        alu_done |=> !alu_done);

endmodule

`default_nettype wire

// ==== rtl/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;

    // restoring divider, one quotient bit per cycle
    localparam int div_steps = 32;
    localparam int div_cnt_w = $clog2(div_steps + 1);

    localparam logic [reg_addr_w-1:0] cp0_status = 5'd12;
    localparam logic [reg_addr_w-1:0] cp0_cause  = 5'd13;
    localparam logic [reg_addr_w-1:0] cp0_epc    = 5'd14;

    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui,
        alu_move,
        alu_mult,
        alu_multu,
        alu_div,
        alu_divu
    } alu_op_t;

    typedef enum logic [1:0] {
        src_a_zero,
        src_a_rs,
        src_a_rt,
        src_a_sa
    } src_a_sel_t;

    typedef enum logic [1:0] {
        src_b_zero,
        src_b_rt,
        src_b_imme,
        src_b_rs
    } src_b_sel_t;

    typedef enum logic [2:0] {
        res_alu,
        res_hi,
        res_lo,
        res_pc_8,
        res_cp0
    } res_sel_t;

endpackage

`default_nettype wire

// ==== rtl/ex_top.sv ====
`default_nettype none

module ex_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  ex_pkg::src_a_sel_t            src_a_sel,
    input  ex_pkg::src_b_sel_t            src_b_sel,
    input  ex_pkg::alu_op_t               alu_op,
    input  ex_pkg::res_sel_t              res_sel,
    input  logic                          w_reg_ena,
    input  logic [ex_pkg::reg_addr_w-1:0] w_reg_dst,
    input  logic [1:0]                    w_hilo_ena,
    input  logic                          w_cp0_ena,
    input  logic [ex_pkg::reg_addr_w-1:0] rd,
    input  logic [ex_pkg::reg_addr_w-1:0] sa,
    input  logic [ex_pkg::data_w-1:0]     rs_data,
    input  logic [ex_pkg::data_w-1:0]     rt_data,
    input  logic [ex_pkg::data_w-1:0]     ext_imme,
    input  logic [ex_pkg::data_w-1:0]     pc,
    output logic                          out_valid,
    output logic [ex_pkg::data_w-1:0]     out_res,
    output logic                          out_w_reg_ena,
    output logic [ex_pkg::reg_addr_w-1:0] out_w_reg_dst,
    output logic [ex_pkg::data_w-1:0]     out_pc
);

    import ex_pkg::*;

    logic [data_w-1:0]     hi;
    logic [data_w-1:0]     lo;
    logic [1:0]            hilo_w_ena;
    logic [data_w-1:0]     hi_in;
    logic [data_w-1:0]     lo_in;
    logic                  cp0_w_ena;
    logic [reg_addr_w-1:0] cp0_addr;
    logic [data_w-1:0]     cp0_w_data;
    logic [data_w-1:0]     cp0_r_data;

    ex i_ex (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .src_a_sel     (src_a_sel),
        .src_b_sel     (src_b_sel),
        .alu_op        (alu_op),
        .res_sel       (res_sel),
        .w_reg_ena     (w_reg_ena),
        .w_reg_dst     (w_reg_dst),
        .w_hilo_ena    (w_hilo_ena),
        .w_cp0_ena     (w_cp0_ena),
        .rd            (rd),
        .sa            (sa),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .ext_imme      (ext_imme),
        .pc            (pc),
        .hi            (hi),
        .lo            (lo),
        .cp0_r_data    (cp0_r_data),
        .hilo_w_ena    (hilo_w_ena),
        .hi_in         (hi_in),
        .lo_in         (lo_in),
        .cp0_w_ena     (cp0_w_ena),
        .cp0_addr      (cp0_addr),
        .cp0_w_data    (cp0_w_data),
        .out_valid     (out_valid),
        .out_res       (out_res),
        .out_w_reg_ena (out_w_reg_ena),
        .out_w_reg_dst (out_w_reg_dst),
        .out_pc        (out_pc)
    );

    hilo_reg i_hilo_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .w_ena (hilo_w_ena),
        .hi_in (hi_in),
        .lo_in (lo_in),
        .hi    (hi),
        .lo    (lo)
    );

    // mfc0 and mtc0 share the rd address
    cp0_regs i_cp0_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .w_ena  (cp0_w_ena),
        .w_addr (cp0_addr),
        .w_data (cp0_w_data),
        .r_addr (cp0_addr),
        .r_data (cp0_r_data)
    );

endmodule

`default_nettype wire

// ==== rtl/hilo_reg.sv ====
`default_nettype none

module hilo_reg (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [1:0]                w_ena,
    input  logic [ex_pkg::data_w-1:0] hi_in,
    input  logic [ex_pkg::data_w-1:0] lo_in,
    output logic [ex_pkg::data_w-1:0] hi,
    output logic [ex_pkg::data_w-1:0] lo
);

    // bit 1 writes hi, bit 0 writes lo
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi <= '0;
        end else if (w_ena[1]) begin
            hi <= hi_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lo <= '0;
        end else if (w_ena[0]) begin
            lo <= lo_in;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_ex_top.sv ====
`default_nettype none

module tb_ex_top;

    import ex_pkg::*;

    localparam int n_instr    = 600;
    localparam int wait_limit = 2 * div_steps + 20;

    typedef struct packed {
        logic [data_w-1:0]     res;
        logic [data_w-1:0]     pc;
        logic [reg_addr_w-1:0] dst;
        logic                  ena;
        logic                  is_div;
    } expect_t;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic                  in_ready;
    src_a_sel_t            src_a_sel;
    src_b_sel_t            src_b_sel;
    alu_op_t               alu_op;
    res_sel_t              res_sel;
    logic                  w_reg_ena;
    logic [reg_addr_w-1:0] w_reg_dst;
    logic [1:0]            w_hilo_ena;
    logic                  w_cp0_ena;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] sa;
    logic [data_w-1:0]     rs_data;
    logic [data_w-1:0]     rt_data;
    logic [data_w-1:0]     ext_imme;
    logic [data_w-1:0]     pc;
    logic                  out_valid;
    logic [data_w-1:0]     out_res;
    logic                  out_w_reg_ena;
    logic [reg_addr_w-1:0] out_w_reg_dst;
    logic [data_w-1:0]     out_pc;

    int seed;
    int errors;
    int checks;
    int accepted;
    int outputs;
    expect_t exp_q[$];
    logic div_pending;
    logic timed_out;

    // reference architectural state
    logic [data_w-1:0] m_hi;
    logic [data_w-1:0] m_lo;
    logic [data_w-1:0] m_status;
    logic [data_w-1:0] m_cause;
    logic [data_w-1:0] m_epc;

    ex_top i_ex_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .src_a_sel     (src_a_sel),
        .src_b_sel     (src_b_sel),
        .alu_op        (alu_op),
        .res_sel       (res_sel),
        .w_reg_ena     (w_reg_ena),
        .w_reg_dst     (w_reg_dst),
        .w_hilo_ena    (w_hilo_ena),
        .w_cp0_ena     (w_cp0_ena),
        .rd            (rd),
        .sa            (sa),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .ext_imme      (ext_imme),
        .pc            (pc),
        .out_valid     (out_valid),
        .out_res       (out_res),
        .out_w_reg_ena (out_w_reg_ena),
        .out_w_reg_dst (out_w_reg_dst),
        .out_pc        (out_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] rand_below(input int unsigned n);
        return rand_word() % n;
    endfunction

    // corner values often enough to hit zero divisors and sign edges
    function automatic logic [31:0] pick_operand();
        case (rand_below(8))
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            4:       return rand_below(16);
            default: return rand_word();
        endcase
    endfunction

    function automatic logic [31:0] ref_alu(input alu_op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [4:0] amount;
        amount = a[4:0];
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_nor:  return ~(a | b);
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_sll:  return b << amount;
            alu_srl:  return b >> amount;
            alu_sra:  return 32'($signed(b) >>> amount);
            alu_lui:  return {b[15:0], 16'h0000};
            default:  return 32'h0000_0000;
        endcase
    endfunction

    task automatic ref_div(input logic signed_op, input logic [31:0] a, input logic [31:0] b,
                           output logic [31:0] q, output logic [31:0] r);
        logic        neg_a;
        logic        neg_b;
        logic [31:0] mag_a;
        logic [31:0] mag_b;
        logic [31:0] uq;
        logic [31:0] ur;
        neg_a = signed_op && a[31];
        neg_b = signed_op && b[31];
        mag_a = neg_a ? -a : a;
        mag_b = neg_b ? -b : b;
        if (mag_b == 32'd0) begin
            uq = 32'hffff_ffff;
            ur = mag_a;
        end else begin
            uq = mag_a / mag_b;
            ur = mag_a % mag_b;
        end
        q = (neg_a != neg_b) ? -uq : uq;
        r = neg_a ? -ur : ur;
    endtask

    function automatic logic [31:0] cp0_read(input logic [4:0] addr);
        case (addr)
            5'd12:   return m_status;
            5'd13:   return m_cause;
            5'd14:   return m_epc;
            default: return 32'h0000_0000;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic report_counts();
        $display("errors %0d, checks %0d, accepted %0d, outputs %0d",
                 errors, checks, accepted, outputs);
    endtask

    task automatic note_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("%s", what);
    endtask

    // expected result from the state before this instruction
    task automatic model_accept();
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        res;
        logic [31:0]        q;
        logic [31:0]        r;
        logic [31:0]        new_hi;
        logic [31:0]        new_lo;
        logic signed [63:0] sprod;
        logic [63:0]        uprod;
        expect_t            e;
        case (src_a_sel)
            src_a_zero: a = 32'd0;
            src_a_rs:   a = rs_data;
            src_a_rt:   a = rt_data;
            default:    a = {27'd0, sa};
        endcase
        case (src_b_sel)
            src_b_zero: b = 32'd0;
            src_b_rt:   b = rt_data;
            src_b_imme: b = ext_imme;
            default:    b = rs_data;
        endcase
        case (res_sel)
            res_hi:   res = m_hi;
            res_lo:   res = m_lo;
            res_pc_8: res = pc + 32'd8;
            res_cp0:  res = cp0_read(rd);
            default:  res = ref_alu(alu_op, a, b);
        endcase
        new_hi = 32'd0;
        new_lo = 32'd0;
        case (alu_op)
            alu_mult: begin
                sprod  = 64'($signed(a)) * 64'($signed(b));
                new_hi = sprod[63:32];
                new_lo = sprod[31:0];
            end
            alu_multu: begin
                uprod  = 64'(a) * 64'(b);
                new_hi = uprod[63:32];
                new_lo = uprod[31:0];
            end
            alu_move: begin
                new_hi = a;
                new_lo = a;
            end
            alu_div, alu_divu: begin
                ref_div(alu_op == alu_div, a, b, q, r);
                new_hi = r;
                new_lo = q;
            end
            default: ;
        endcase
        if (w_cp0_ena) begin
            case (rd)
                5'd12:   m_status = rt_data;
                5'd13:   m_cause  = rt_data;
                5'd14:   m_epc    = rt_data;
                default: ;
            endcase
        end
        if (w_hilo_ena[1]) begin
            m_hi = new_hi;
        end
        if (w_hilo_ena[0]) begin
            m_lo = new_lo;
        end
        e.res    = res;
        e.pc     = pc;
        e.dst    = w_reg_dst;
        e.ena    = w_reg_ena;
        e.is_div = alu_op inside {alu_div, alu_divu};
        if (e.is_div) begin
            div_pending = 1'b1;
        end
        exp_q.push_back(e);
        accepted++;
    endtask

    task automatic collect_output();
        expect_t e;
        if (out_valid) begin
            outputs++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("out_valid pulsed with no instruction pending at %0t", $time);
            end else begin
                e = exp_q.pop_front();
                if (e.is_div) begin
                    div_pending = 1'b0;
                end
                check_value("out_res", out_res, e.res);
                check_value("out_pc", out_pc, e.pc);
                check_value("out_w_reg_dst", {27'd0, out_w_reg_dst}, {27'd0, e.dst});
                check_value("out_w_reg_ena", {31'd0, out_w_reg_ena}, {31'd0, e.ena});
            end
        end
    endtask

    // ready is low exactly while a divide is outstanding
    task automatic step_cycle();
        @(negedge clk);
        collect_output();
        check_value("in_ready", {31'd0, in_ready}, {31'd0, !div_pending});
    endtask

    task automatic drive_random();
        logic uses_hilo;
        in_valid   = (rand_below(8) != 0);
        alu_op     = alu_op_t'(5'(rand_below(17)));
        src_a_sel  = src_a_sel_t'(2'(rand_below(4)));
        src_b_sel  = src_b_sel_t'(2'(rand_below(4)));
        uses_hilo  = alu_op inside {alu_mult, alu_multu, alu_move, alu_div, alu_divu};
        // hi/lo producers report through a non-alu result path
        if (uses_hilo) begin
            res_sel    = res_sel_t'(3'(1 + rand_below(4)));
            w_hilo_ena = 2'(rand_below(4));
        end else begin
            res_sel    = res_sel_t'(3'(rand_below(5)));
            w_hilo_ena = 2'b00;
        end
        w_cp0_ena = (rand_below(4) == 0);
        if (rand_below(2) != 0) begin
            rd = 5'd12 + 5'(rand_below(3));
        end else begin
            rd = 5'(rand_word());
        end
        sa        = 5'(rand_word());
        rs_data   = pick_operand();
        rt_data   = pick_operand();
        ext_imme  = pick_operand();
        pc        = rand_word() & 32'hffff_fffc;
        w_reg_ena = 1'(rand_word());
        w_reg_dst = 5'(rand_word());
    endtask

    initial begin
        int wait_cnt;
        seed        = 32'h1ef54c1e;
        errors      = 0;
        checks      = 0;
        accepted    = 0;
        outputs     = 0;
        div_pending = 1'b0;
        timed_out   = 1'b0;
        m_hi        = '0;
        m_lo        = '0;
        m_status    = '0;
        m_cause     = '0;
        m_epc       = '0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        src_a_sel   = src_a_zero;
        src_b_sel   = src_b_zero;
        alu_op      = alu_add;
        res_sel     = res_alu;
        w_reg_ena   = 1'b0;
        w_reg_dst   = '0;
        w_hilo_ena  = 2'b00;
        w_cp0_ena   = 1'b0;
        rd          = '0;
        sa          = '0;
        rs_data     = '0;
        rt_data     = '0;
        ext_imme    = '0;
        pc          = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("in_ready", {31'd0, in_ready}, 32'd1);
        check_value("out_valid", {31'd0, out_valid}, 32'd0);

        for (int i = 0; i < n_instr && !timed_out; i++) begin
            step_cycle();
            drive_random();
            if (in_valid) begin
                wait_cnt = 0;
                while (!in_ready && !timed_out) begin
                    if (wait_cnt >= wait_limit) begin
                        note_timeout("in_ready stuck low, the divider never finished");
                    end else begin
                        step_cycle();
                        wait_cnt++;
                    end
                end
                if (!timed_out) begin
                    model_accept();
                end
            end
        end

        if (!timed_out) begin
            step_cycle();
        end
        in_valid = 1'b0;
        wait_cnt = 0;
        while (exp_q.size() != 0 && !timed_out) begin
            if (wait_cnt >= wait_limit) begin
                note_timeout("timed out waiting for out_valid of pending instructions");
            end else begin
                step_cycle();
                wait_cnt++;
            end
        end
        if (!timed_out) begin
            // idle cycles catch any extra output pulse
            repeat (4) step_cycle();
            check_value("output count", 32'(outputs), 32'(accepted));
        end

        report_counts();
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
